// ==== include/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define XLEN      32
`define REG_AW    5
`define RESET_PC  32'hBFC0_0000
`define LINK_REG  5'd31

// primary opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_JAL    6'h03
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDIU  6'h09
`define OP_SLTI   6'h0A
`define OP_ANDI   6'h0C
`define OP_ORI    6'h0D
`define OP_LUI    6'h0F
`define OP_LW     6'h23
`define OP_SW     6'h2B

// funct field of R-type
`define FN_SLL    6'h00
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_XOR    6'h26
`define FN_SLT    6'h2A

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLT   4'd5
`define ALU_SLL   4'd6
`define ALU_LUI   4'd7

// operand source in decode
`define FWD_REG   2'd0
`define FWD_EX    2'd1
`define FWD_MEM   2'd2
`define FWD_WB    2'd3

`endif

// ==== source/mipsPkg.sv ====
`include "mips_macros.svh"

package mipsPkg;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [4:0]         shamt;
        logic [5:0]         funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [15:0]        imm;
    } iFmtT;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jFmtT;

    // one instruction word, three field layouts
    typedef union packed {
        rFmtT r;
        iFmtT i;
        jFmtT j;
    } instrT;

endpackage

// ==== source/hazardBus.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

interface hazardBus (
    input logic clk
);
    logic               stallF;
    logic               stallD;
    logic               flushD;
    logic               flushE;
    logic               freeze;     // data port stall, holds E, M and W
    logic [1:0]         fwdA;
    logic [1:0]         fwdB;
    logic [`REG_AW-1:0] rsD;
    logic [`REG_AW-1:0] rtD;
    logic [`REG_AW-1:0] wregE;
    logic [`REG_AW-1:0] wregM;
    logic [`REG_AW-1:0] wregW;
    logic               regWriteE;
    logic               regWriteM;
    logic               regWriteW;
    logic               memReadE;
    logic               takenE;

    modport ctl (
        input  clk, rsD, rtD, wregE, wregM, wregW, regWriteE, regWriteM, regWriteW,
        input  memReadE, takenE,
        output stallF, stallD, flushD, flushE, freeze, fwdA, fwdB
    );

    modport stage (
        input  stallF, stallD, flushD, flushE, freeze, fwdA, fwdB,
        output rsD, rtD, wregE, wregM, wregW, regWriteE, regWriteM, regWriteW,
        output memReadE, takenE
    );
endinterface

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module regFile (
    input  logic               clk,
    input  logic               arstN_i,
    input  logic [`REG_AW-1:0] raddrA_i,
    input  logic [`REG_AW-1:0] raddrB_i,
    input  logic               we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i,
    output logic [`XLEN-1:0]   rdataA_o,
    output logic [`XLEN-1:0]   rdataB_o
);
    logic [`XLEN-1:0] regs [0:(1 << `REG_AW)-1];

    // r0 keeps its reset value since it is never written
    assign rdataA_o = regs[raddrA_i];
    assign rdataB_o = regs[raddrB_i];

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < (1 << `REG_AW); i++)
                regs[i] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetchStage (
    input  logic             clk,
    input  logic             arstN_i,
    hazardBus.stage          hz_i,
    input  logic             jumpD_i,
    input  logic [`XLEN-1:0] jumpTargetD_i,
    input  logic             takenE_i,
    input  logic [`XLEN-1:0] branchTargetE_i,
    output logic [`XLEN-1:0] pc_o,
    output logic [`XLEN-1:0] pcF_o
);
    logic [`XLEN-1:0] pcNext;

    // resolved branch wins over a jump sitting in decode
    always_comb begin
        if (takenE_i)
            pcNext = branchTargetE_i;
        else if (jumpD_i)
            pcNext = jumpTargetD_i;
        else
            pcNext = pc_o + 32'd4;
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i)
            pc_o <= `RESET_PC;
        else if (!hz_i.stallF)
            pc_o <= pcNext;
    end

    assign pcF_o = pc_o;  // travels with instr_i into decode

    // targets come from decode and execute, both must keep word alignment
    assert property (@(posedge clk) disable iff (!arstN_i) pc_o[1:0] == 2'b00);

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module decodeStage (
    input  logic               clk,
    input  logic               arstN_i,
    hazardBus.stage            hz_i,
    input  logic [`XLEN-1:0]   pcF_i,
    input  mipsPkg::instrT     instrF_i,
    input  logic [`XLEN-1:0]   aluOutE_i,
    input  logic [`XLEN-1:0]   resultM_i,
    input  logic [`XLEN-1:0]   resultW_i,
    input  logic [`REG_AW-1:0] wregW_i,
    input  logic               regWriteW_i,
    output logic               jumpD_o,
    output logic [`XLEN-1:0]   jumpTargetD_o,
    output logic [`XLEN-1:0]   opAE_o,
    output logic [`XLEN-1:0]   opBE_o,
    output logic [`XLEN-1:0]   storeDataE_o,
    output logic [3:0]         aluOpE_o,
    output logic [`REG_AW-1:0] wregE_o,
    output logic               regWriteE_o,
    output logic               memReadE_o,
    output logic               memWriteE_o,
    output logic               branchE_o,
    output logic               branchNeE_o,
    output logic [`XLEN-1:0]   branchTargetE_o,
    output logic [`XLEN-1:0]   pcE_o
);
    import mipsPkg::*;

    instrT              instrD;
    logic [`XLEN-1:0]   pcD;
    logic [`XLEN-1:0]   rdataA;
    logic [`XLEN-1:0]   rdataB;
    logic [`XLEN-1:0]   fwdValA;
    logic [`XLEN-1:0]   fwdValB;
    logic [`XLEN-1:0]   immExt;
    logic [3:0]         aluOp;
    logic [`REG_AW-1:0] wreg;
    logic               useImm;
    logic               zeroExt;
    logic               isShift;
    logic               isJal;
    logic               regWrite;
    logic               memRead;
    logic               memWrite;
    logic               branch;
    logic               branchNe;

    // fetch/decode register, a flush leaves a nop behind
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            instrD <= '0;
            pcD    <= `RESET_PC;
        end else if (!hz_i.stallD) begin
            instrD <= hz_i.flushD ? '0 : instrF_i;
            pcD    <= pcF_i;
        end
    end

    regFile rf (
        .clk(clk), .arstN_i(arstN_i),
        .raddrA_i(instrD.r.rs), .raddrB_i(instrD.r.rt),
        .we_i(regWriteW_i), .waddr_i(wregW_i), .wdata_i(resultW_i),
        .rdataA_o(rdataA), .rdataB_o(rdataB)
    );

    assign hz_i.rsD = instrD.r.rs;
    assign hz_i.rtD = instrD.r.rt;

    always_comb begin
        aluOp    = `ALU_ADD;
        wreg     = instrD.r.rd;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        isShift  = 1'b0;
        isJal    = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        jumpD_o  = 1'b0;
        case (instrD.r.op)
            `OP_RTYPE: begin
                regWrite = 1'b1;
                case (instrD.r.funct)
                    `FN_ADDU: aluOp = `ALU_ADD;
                    `FN_SUBU: aluOp = `ALU_SUB;
                    `FN_AND:  aluOp = `ALU_AND;
                    `FN_OR:   aluOp = `ALU_OR;
                    `FN_XOR:  aluOp = `ALU_XOR;
                    `FN_SLT:  aluOp = `ALU_SLT;
                    `FN_SLL: begin
                        aluOp   = `ALU_SLL;
                        isShift = 1'b1;  // rt shifted by shamt
                        useImm  = 1'b1;
                    end
                    default:  regWrite = 1'b0;
                endcase
            end
            `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI, `OP_LW: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                wreg     = instrD.i.rt;
                memRead  = instrD.i.op == `OP_LW;
                zeroExt  = instrD.i.op == `OP_ANDI || instrD.i.op == `OP_ORI;
                case (instrD.i.op)
                    `OP_SLTI: aluOp = `ALU_SLT;
                    `OP_ANDI: aluOp = `ALU_AND;
                    `OP_ORI:  aluOp = `ALU_OR;
                    `OP_LUI:  aluOp = `ALU_LUI;
                    default:  aluOp = `ALU_ADD;  // addiu, lw address
                endcase
            end
            `OP_SW: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                branch   = 1'b1;
                branchNe = instrD.i.op == `OP_BNE;
            end
            `OP_J:
                jumpD_o = 1'b1;
            `OP_JAL: begin
                jumpD_o  = 1'b1;
                isJal    = 1'b1;
                regWrite = 1'b1;
                wreg     = `LINK_REG;
            end
            default: ;  // unknown opcode runs as a nop
        endcase
    end

    assign immExt = zeroExt ? {16'b0, instrD.i.imm} : {{16{instrD.i.imm[15]}}, instrD.i.imm};

    always_comb begin
        case (hz_i.fwdA)
            `FWD_EX:  fwdValA = aluOutE_i;
            `FWD_MEM: fwdValA = resultM_i;
            `FWD_WB:  fwdValA = resultW_i;
            default:  fwdValA = rdataA;
        endcase
        case (hz_i.fwdB)
            `FWD_EX:  fwdValB = aluOutE_i;
            `FWD_MEM: fwdValB = resultM_i;
            `FWD_WB:  fwdValB = resultW_i;
            default:  fwdValB = rdataB;
        endcase
    end

    assign jumpTargetD_o = {pcD[31:28], instrD.j.target, 2'b00};

    // decode/execute control, bubble on flushE
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteE_o <= 1'b0;
            memReadE_o  <= 1'b0;
            memWriteE_o <= 1'b0;
            branchE_o   <= 1'b0;
            wregE_o     <= '0;
        end else if (!hz_i.freeze) begin
            regWriteE_o <= regWrite && !hz_i.flushE;
            memReadE_o  <= memRead && !hz_i.flushE;
            memWriteE_o <= memWrite && !hz_i.flushE;
            branchE_o   <= branch && !hz_i.flushE;
            wregE_o     <= wreg;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz_i.freeze) begin
            opAE_o          <= isJal ? pcD + 32'd8 : (isShift ? fwdValB : fwdValA);
            opBE_o          <= isJal ? '0 : (useImm ? immExt : fwdValB);
            storeDataE_o    <= fwdValB;
            aluOpE_o        <= aluOp;
            branchNeE_o     <= branchNe;
            branchTargetE_o <= pcD + 32'd4 + {immExt[`XLEN-3:0], 2'b00};
            pcE_o           <= pcD;
        end
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module executeStage (
    input  logic               clk,
    input  logic               arstN_i,
    hazardBus.stage            hz_i,
    input  logic [`XLEN-1:0]   opAE_i,
    input  logic [`XLEN-1:0]   opBE_i,
    input  logic [`XLEN-1:0]   storeDataE_i,
    input  logic [3:0]         aluOpE_i,
    input  logic [`REG_AW-1:0] wregE_i,
    input  logic               regWriteE_i,
    input  logic               memReadE_i,
    input  logic               memWriteE_i,
    input  logic               branchE_i,
    input  logic               branchNeE_i,
    input  logic [`XLEN-1:0]   branchTargetE_i,
    input  logic [`XLEN-1:0]   pcE_i,
    output logic [`XLEN-1:0]   aluOutE_o,
    output logic               takenE_o,
    output logic [`XLEN-1:0]   branchTargetE_o,
    output logic [`XLEN-1:0]   aluOutM_o,
    output logic [`XLEN-1:0]   storeDataM_o,
    output logic [`REG_AW-1:0] wregM_o,
    output logic               regWriteM_o,
    output logic               memReadM_o,
    output logic               memWriteM_o,
    output logic [`XLEN-1:0]   pcM_o
);
    always_comb begin
        case (aluOpE_i)
            `ALU_SUB: aluOutE_o = opAE_i - opBE_i;
            `ALU_AND: aluOutE_o = opAE_i & opBE_i;
            `ALU_OR:  aluOutE_o = opAE_i | opBE_i;
            `ALU_XOR: aluOutE_o = opAE_i ^ opBE_i;
            `ALU_SLT: aluOutE_o = {{(`XLEN-1){1'b0}}, $signed(opAE_i) < $signed(opBE_i)};
            `ALU_SLL: aluOutE_o = opAE_i << opBE_i[10:6];  // shamt field of the imm
            `ALU_LUI: aluOutE_o = {opBE_i[15:0], 16'b0};
            default:  aluOutE_o = opAE_i + opBE_i;
        endcase
    end

    assign takenE_o        = branchE_i && ((opAE_i == opBE_i) != branchNeE_i);
    assign branchTargetE_o = branchTargetE_i;

    assign hz_i.wregE     = wregE_i;
    assign hz_i.regWriteE = regWriteE_i;
    assign hz_i.memReadE  = memReadE_i;
    assign hz_i.takenE    = takenE_o;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteM_o <= 1'b0;
            memReadM_o  <= 1'b0;
            memWriteM_o <= 1'b0;
            wregM_o     <= '0;
        end else if (!hz_i.freeze) begin
            regWriteM_o <= regWriteE_i;
            memReadM_o  <= memReadE_i;
            memWriteM_o <= memWriteE_i;
            wregM_o     <= wregE_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz_i.freeze) begin
            aluOutM_o    <= aluOutE_o;
            storeDataM_o <= storeDataE_i;
            pcM_o        <= pcE_i;
        end
    end

endmodule

// ==== source/memWbStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module memWbStage (
    input  logic               clk,
    input  logic               arstN_i,
    hazardBus.stage            hz_i,
    input  logic [`XLEN-1:0]   aluOutM_i,
    input  logic [`XLEN-1:0]   storeDataM_i,
    input  logic [`REG_AW-1:0] wregM_i,
    input  logic               regWriteM_i,
    input  logic               memReadM_i,
    input  logic               memWriteM_i,
    input  logic [`XLEN-1:0]   pcM_i,
    input  logic [`XLEN-1:0]   memRdata_i,
    output logic               memEn_o,
    output logic               memWe_o,
    output logic [`XLEN-1:0]   memAddr_o,
    output logic [`XLEN-1:0]   memWdata_o,
    output logic [`XLEN-1:0]   resultM_o,
    output logic [`XLEN-1:0]   resultW_o,
    output logic [`REG_AW-1:0] wregW_o,
    output logic               regWriteW_o,
    output logic [`XLEN-1:0]   wbPc_o,
    output logic               wbWen_o,
    output logic [`REG_AW-1:0] wbWnum_o,
    output logic [`XLEN-1:0]   wbWdata_o
);
    assign memEn_o    = memReadM_i || memWriteM_i;
    assign memWe_o    = memWriteM_i;
    assign memAddr_o  = aluOutM_i;
    assign memWdata_o = storeDataM_i;
    assign resultM_o  = memReadM_i ? memRdata_i : aluOutM_i;  // read data is combinational

    assign hz_i.wregM     = wregM_i;
    assign hz_i.regWriteM = regWriteM_i;
    assign hz_i.wregW     = wregW_o;
    assign hz_i.regWriteW = regWriteW_o;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteW_o <= 1'b0;
            wregW_o     <= '0;
        end else if (!hz_i.freeze) begin
            regWriteW_o <= regWriteM_i;
            wregW_o     <= wregM_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz_i.freeze) begin
            resultW_o <= resultM_o;
            wbPc_o    <= pcM_i;
        end
    end

    // reported once, on the cycle the writeback register leaves
    assign wbWen_o   = regWriteW_o && !hz_i.freeze && wregW_o != '0;
    assign wbWnum_o  = wregW_o;
    assign wbWdata_o = resultW_o;

    // a stalled access keeps the data port steady until accepted
    assert property (@(posedge clk) disable iff (!arstN_i)
        memEn_o && hz_i.freeze |=> memEn_o && $stable(memWe_o) && $stable(memAddr_o)
                                   && $stable(memWdata_o));

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module hazardUnit (
    input logic   memStall_i,
    hazardBus.ctl hz_o
);
    logic loadUse;

    // nearest producer first, r0 never forwarded
    function automatic logic [1:0] pickFwd(input logic [`REG_AW-1:0] src);
        if (src == '0)
            return `FWD_REG;
        if (hz_o.regWriteE && hz_o.wregE == src)
            return `FWD_EX;
        if (hz_o.regWriteM && hz_o.wregM == src)
            return `FWD_MEM;
        if (hz_o.regWriteW && hz_o.wregW == src)
            return `FWD_WB;
        return `FWD_REG;
    endfunction

    always_comb begin
        hz_o.fwdA = pickFwd(hz_o.rsD);
        hz_o.fwdB = pickFwd(hz_o.rtD);
    end

    // load data only exists from memory onward
    assign loadUse = hz_o.memReadE && hz_o.wregE != '0 &&
                     (hz_o.wregE == hz_o.rsD || hz_o.wregE == hz_o.rtD);

    assign hz_o.freeze = memStall_i;
    assign hz_o.stallF = loadUse || memStall_i;
    assign hz_o.stallD = loadUse || memStall_i;
    assign hz_o.flushD = hz_o.takenE && !memStall_i;  // drop the instruction after the slot
    assign hz_o.flushE = loadUse && !memStall_i;

    // a taken branch in execute never coincides with a held decode register
    assert property (@(posedge hz_o.clk) !(hz_o.flushD && hz_o.stallD));

endmodule

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore (
    input  logic               clk,
    input  logic               arstN_i,
    input  logic [`XLEN-1:0]   instr_i,
    input  logic [`XLEN-1:0]   memRdata_i,
    input  logic               memStall_i,
    output logic [`XLEN-1:0]   pc_o,
    output logic               memEn_o,
    output logic               memWe_o,
    output logic [`XLEN-1:0]   memAddr_o,
    output logic [`XLEN-1:0]   memWdata_o,
    output logic [`XLEN-1:0]   wbPc_o,
    output logic               wbWen_o,
    output logic [`REG_AW-1:0] wbWnum_o,
    output logic [`XLEN-1:0]   wbWdata_o
);
    logic [`XLEN-1:0]   pcF, jumpTargetD, branchTargetRegE, branchTargetE;
    logic               jumpD, takenE;
    logic [`XLEN-1:0]   opAE, opBE, storeDataE, pcE, aluOutE;
    logic [3:0]         aluOpE;
    logic [`REG_AW-1:0] wregE, wregM, wregW;
    logic               regWriteE, memReadE, memWriteE, branchE, branchNeE;
    logic [`XLEN-1:0]   aluOutM, storeDataM, pcM, resultM, resultW;
    logic               regWriteM, memReadM, memWriteM, regWriteW;

    hazardBus hz (.clk(clk));

    hazardUnit hazard (.memStall_i(memStall_i), .hz_o(hz.ctl));

    fetchStage fetch (
        .clk(clk), .arstN_i(arstN_i), .hz_i(hz.stage),
        .jumpD_i(jumpD), .jumpTargetD_i(jumpTargetD),
        .takenE_i(takenE), .branchTargetE_i(branchTargetE),
        .pc_o(pc_o), .pcF_o(pcF)
    );

    decodeStage decode (
        .clk(clk), .arstN_i(arstN_i), .hz_i(hz.stage),
        .pcF_i(pcF), .instrF_i(instr_i),
        .aluOutE_i(aluOutE), .resultM_i(resultM), .resultW_i(resultW),
        .wregW_i(wregW), .regWriteW_i(regWriteW),
        .jumpD_o(jumpD), .jumpTargetD_o(jumpTargetD),
        .opAE_o(opAE), .opBE_o(opBE), .storeDataE_o(storeDataE), .aluOpE_o(aluOpE),
        .wregE_o(wregE), .regWriteE_o(regWriteE), .memReadE_o(memReadE),
        .memWriteE_o(memWriteE), .branchE_o(branchE), .branchNeE_o(branchNeE),
        .branchTargetE_o(branchTargetRegE), .pcE_o(pcE)
    );

    executeStage execute (
        .clk(clk), .arstN_i(arstN_i), .hz_i(hz.stage),
        .opAE_i(opAE), .opBE_i(opBE), .storeDataE_i(storeDataE), .aluOpE_i(aluOpE),
        .wregE_i(wregE), .regWriteE_i(regWriteE), .memReadE_i(memReadE),
        .memWriteE_i(memWriteE), .branchE_i(branchE), .branchNeE_i(branchNeE),
        .branchTargetE_i(branchTargetRegE), .pcE_i(pcE),
        .aluOutE_o(aluOutE), .takenE_o(takenE), .branchTargetE_o(branchTargetE),
        .aluOutM_o(aluOutM), .storeDataM_o(storeDataM), .wregM_o(wregM),
        .regWriteM_o(regWriteM), .memReadM_o(memReadM), .memWriteM_o(memWriteM),
        .pcM_o(pcM)
    );

    memWbStage memWb (
        .clk(clk), .arstN_i(arstN_i), .hz_i(hz.stage),
        .aluOutM_i(aluOutM), .storeDataM_i(storeDataM), .wregM_i(wregM),
        .regWriteM_i(regWriteM), .memReadM_i(memReadM), .memWriteM_i(memWriteM),
        .pcM_i(pcM), .memRdata_i(memRdata_i),
        .memEn_o(memEn_o), .memWe_o(memWe_o), .memAddr_o(memAddr_o), .memWdata_o(memWdata_o),
        .resultM_o(resultM), .resultW_o(resultW), .wregW_o(wregW), .regWriteW_o(regWriteW),
        .wbPc_o(wbPc_o), .wbWen_o(wbWen_o), .wbWnum_o(wbWnum_o), .wbWdata_o(wbWdata_o)
    );

endmodule

// ==== bench/mipsCoreTb.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCoreTb;
    import mipsPkg::*;

    localparam int PROG_LEN   = 200;
    localparam int DMEM_WORDS = 64;
    localparam int MAX_CYCLES = 10 * PROG_LEN + 100;

    logic               clk;
    logic               arstN;
    logic               memStall;
    logic [`XLEN-1:0]   memRdata;
    instrT              instrWord;
    logic [`XLEN-1:0]   pc, memAddr, memWdata, wbPc, wbWdata, pcOffset;
    logic               memEn, memWe, wbWen;
    logic [`REG_AW-1:0] wbWnum;

    instrT              rom [0:PROG_LEN-1];
    logic [`XLEN-1:0]   dmem [0:DMEM_WORDS-1];
    logic               stallPat [0:MAX_CYCLES-1];
    logic [`XLEN-1:0]   expPc [$];
    logic [`REG_AW-1:0] expNum [$];
    logic [`XLEN-1:0]   expData [$];
    logic [`XLEN-1:0]   expStAddr [$];
    logic [`XLEN-1:0]   expStData [$];
    logic [`XLEN-1:0]   haltPc;
    int                 cycleCount;
    int                 resetEdges;
    logic               leftReset;

    mipsCore dut (
        .clk(clk), .arstN_i(arstN), .instr_i(instrWord), .memRdata_i(memRdata),
        .memStall_i(memStall), .pc_o(pc), .memEn_o(memEn), .memWe_o(memWe),
        .memAddr_o(memAddr), .memWdata_o(memWdata), .wbPc_o(wbPc), .wbWen_o(wbWen),
        .wbWnum_o(wbWnum), .wbWdata_o(wbWdata)
    );

    always #2 clk = ~clk;

    // instruction ROM and data memory answer in the same cycle
    assign pcOffset  = (pc - `RESET_PC) >> 2;
    assign instrWord = (pcOffset < PROG_LEN) ? rom[pcOffset[7:0]] : '0;
    // data memory only answers an enabled access
    assign memRdata  = memEn ? dmem[memAddr[7:2]] : ~dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memEn && memWe && !memStall)
            dmem[memAddr[7:2]] <= memWdata;
    end

    function automatic logic [`XLEN-1:0] memInit(input int w);
        return 32'hA5C3_0000 ^ (32'(w) * 32'h0001_0203);
    endfunction

    function automatic logic [`REG_AW-1:0] pickReg();
        int r;
        r = $urandom % 9;
        return (r == 8) ? `LINK_REG : `REG_AW'(r);  // r31 gets jal links
    endfunction

    function automatic instrT rType(input logic [5:0] fn, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [4:0] rd,
                                    input logic [4:0] sh);
        instrT w;
        w.r = '{op: `OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: sh, funct: fn};
        return w;
    endfunction

    function automatic instrT iType(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        instrT w;
        w.i = '{op: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic instrT jType(input logic [5:0] op, input logic [25:0] target);
        instrT w;
        w.j = '{op: op, target: target};
        return w;
    endfunction

    // random code with forward branches and no control in a delay slot
    task automatic buildProgram();
        int               kind;
        int               tgt;
        logic [4:0]       rs, rt, rd;
        logic [15:0]      imm, offs;
        logic [`XLEN-1:0] dest;
        logic             prevCtrl;
        prevCtrl = 1'b0;
        for (int k = 0; k < PROG_LEN - 2; k++) begin
            kind = $urandom % 18;
            if (kind >= 14 && (prevCtrl || k > PROG_LEN - 4))
                kind = $urandom % 14;
            rs   = pickReg();
            rt   = pickReg();
            rd   = pickReg();
            imm  = 16'($urandom);
            offs = 16'(4 * ($urandom % DMEM_WORDS));
            tgt  = k + 2 + $urandom % 10;
            if (tgt > PROG_LEN - 2)
                tgt = PROG_LEN - 2;
            dest = `RESET_PC + 32'(4 * tgt);
            case (kind)
                0:  rom[k] = rType(`FN_ADDU, rs, rt, rd, 5'd0);
                1:  rom[k] = rType(`FN_SUBU, rs, rt, rd, 5'd0);
                2:  rom[k] = rType(`FN_AND, rs, rt, rd, 5'd0);
                3:  rom[k] = rType(`FN_OR, rs, rt, rd, 5'd0);
                4:  rom[k] = rType(`FN_XOR, rs, rt, rd, 5'd0);
                5:  rom[k] = rType(`FN_SLT, rs, rt, rd, 5'd0);
                6:  rom[k] = rType(`FN_SLL, 5'd0, rt, rd, imm[4:0]);
                7:  rom[k] = iType(`OP_ADDIU, rs, rt, imm);
                8:  rom[k] = iType(`OP_SLTI, rs, rt, imm);
                9:  rom[k] = iType(`OP_ANDI, rs, rt, imm);
                10: rom[k] = iType(`OP_ORI, rs, rt, imm);
                11: rom[k] = iType(`OP_LUI, 5'd0, rt, imm);
                12: rom[k] = iType(`OP_LW, 5'd0, rt, offs);
                13: rom[k] = iType(`OP_SW, 5'd0, rt, offs);
                14: rom[k] = iType(`OP_BEQ, rs, rt, 16'(tgt - k - 1));
                15: rom[k] = iType(`OP_BNE, rs, rt, 16'(tgt - k - 1));
                16: rom[k] = jType(`OP_J, dest[27:2]);
                default: rom[k] = jType(`OP_JAL, dest[27:2]);
            endcase
            prevCtrl = kind >= 14;
        end
        haltPc = `RESET_PC + 32'(4 * (PROG_LEN - 2));
        rom[PROG_LEN-2] = jType(`OP_J, haltPc[27:2]);  // parks here forever
        rom[PROG_LEN-1] = '0;
    endtask

    // ISA-level reference with a delay slot after every branch and jump
    function automatic void runModel();
        logic [`XLEN-1:0]   regs [0:31];
        logic [`XLEN-1:0]   mem [0:DMEM_WORDS-1];
        logic [`XLEN-1:0]   cur, npc, nnpc, a, b, simm, res, addr, idx;
        logic [`REG_AW-1:0] dest;
        logic               wr;
        instrT              ins;
        int                 steps;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        for (int w = 0; w < DMEM_WORDS; w++)
            mem[w] = memInit(w);
        cur   = `RESET_PC;
        npc   = cur + 32'd4;
        steps = 0;
        while (cur != haltPc && steps < 4 * PROG_LEN) begin
            idx  = (cur - `RESET_PC) >> 2;
            ins  = rom[idx[7:0]];
            a    = regs[ins.r.rs];
            b    = regs[ins.r.rt];
            simm = {{16{ins.i.imm[15]}}, ins.i.imm};
            addr = a + simm;
            nnpc = npc + 32'd4;
            wr   = 1'b1;
            dest = ins.i.rt;
            res  = '0;
            case (ins.r.op)
                `OP_RTYPE: begin
                    dest = ins.r.rd;
                    case (ins.r.funct)
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        `FN_XOR:  res = a ^ b;
                        `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `FN_SLL:  res = b << ins.r.shamt;
                        default:  wr = 1'b0;
                    endcase
                end
                `OP_ADDIU: res = addr;
                `OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                `OP_ANDI:  res = a & {16'b0, ins.i.imm};
                `OP_ORI:   res = a | {16'b0, ins.i.imm};
                `OP_LUI:   res = {ins.i.imm, 16'b0};
                `OP_LW:    res = mem[addr[7:2]];
                `OP_SW: begin
                    wr = 1'b0;
                    mem[addr[7:2]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                end
                `OP_BEQ, `OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (ins.i.op == `OP_BEQ))
                        nnpc = npc + {simm[`XLEN-3:0], 2'b00};  // relative to the slot
                end
                `OP_J: begin
                    wr   = 1'b0;
                    nnpc = {npc[31:28], ins.j.target, 2'b00};
                end
                `OP_JAL: begin
                    dest = `LINK_REG;
                    res  = cur + 32'd8;
                    nnpc = {npc[31:28], ins.j.target, 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != '0) begin
                regs[dest] = res;
                expPc.push_back(cur);
                expNum.push_back(dest);
                expData.push_back(res);
            end
            cur = npc;
            npc = nnpc;
            steps++;
        end
    endfunction

    task automatic raiseError(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkIdle(input logic [`XLEN-1:0] pcVal, input logic wen, input logic en);
        if (pcVal !== `RESET_PC || wen !== 1'b0 || en !== 1'b0)
            raiseError($sformatf("idle check: pc %h wbWen %b memEn %b", pcVal, wen, en));
    endtask

    task automatic checkWrite(input logic [`XLEN-1:0] wPc, input logic [`REG_AW-1:0] num,
                              input logic [`XLEN-1:0] data);
        if (expPc.size() == 0)
            raiseError($sformatf("unexpected write r%0d = %h from pc %h", num, data, wPc));
        else if (wPc !== expPc[0] || num !== expNum[0] || data !== expData[0])
            raiseError($sformatf("write pc %h r%0d = %h, expected pc %h r%0d = %h",
                                 wPc, num, data, expPc[0], expNum[0], expData[0]));
        else begin
            void'(expPc.pop_front());
            void'(expNum.pop_front());
            void'(expData.pop_front());
        end
    endtask

    task automatic checkStore(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
        if (expStAddr.size() == 0)
            raiseError($sformatf("unexpected store %h to %h", data, addr));
        else if (addr !== expStAddr[0] || data !== expStData[0])
            raiseError($sformatf("store %h to %h, expected %h to %h",
                                 data, addr, expStData[0], expStAddr[0]));
        else begin
            void'(expStAddr.pop_front());
            void'(expStData.pop_front());
        end
    endtask

    // compare process sees the values from before the edge
    always @(posedge clk) begin
        if (!arstN) begin
            if (resetEdges > 0)
                checkIdle(pc, wbWen, memEn);
            resetEdges = resetEdges + 1;
        end else begin
            if (!leftReset) begin
                checkIdle(pc, wbWen, memEn);
                leftReset = 1'b1;
            end
            if (wbWen)
                checkWrite(wbPc, wbWnum, wbWdata);
            if (memEn && memWe && !memStall)
                checkStore(memAddr, memWdata);
        end
    end

    // data port back-pressure and run limit
    always @(posedge clk) begin
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: program not finished after %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1);
        end else begin
            memStall   <= arstN && stallPat[cycleCount];
            cycleCount <= cycleCount + 1;
        end
    end

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        memStall   = 1'b0;
        cycleCount = 0;
        resetEdges = 0;
        leftReset  = 1'b0;
        void'($urandom(66));
        buildProgram();
        for (int w = 0; w < DMEM_WORDS; w++)
            dmem[w] = memInit(w);
        for (int c = 0; c < MAX_CYCLES; c++)
            stallPat[c] = ($urandom % 100) < 30;  // about 30% stalled
        runModel();
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        // the halt delay slot leaving writeback ends the program
        @(posedge clk);
        while (!(wbPc === haltPc + 32'd4 && !memStall))
            @(posedge clk);
        if (expPc.size() == 0 && expStAddr.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("program ended with %0d writes and %0d stores missing",
                     expPc.size(), expStAddr.size());
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

// ==== sources.f ====
+incdir+include
source/mipsPkg.sv
source/hazardBus.sv
source/regFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memWbStage.sv
source/hazardUnit.sv
source/mipsCore.sv
bench/mipsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mipsCoreTb -f sources.f -o mipsCoreSim

simOut=$(./obj_dir/mipsCoreSim || true)
echo "$simOut"

if grep -qx "Done: no errors" <<< "$simOut"; then
    exit 0
fi
exit 1
